//--- vlog.f
+incdir+verilog
verilog/lm80c_bus_pkg.sv
verilog/lm80c_mem_pkg.sv
verilog/lm80c_clock_enables.sv
verilog/lm80c_bus_decoder.sv
verilog/lm80c_memory_port.sv
verilog/lm80c_read_mux.sv
verilog/lm80c_core.sv
verif/lm80c_core_tb.sv

//--- Makefile
# Verilator build and run of the LM80C core testbench

TOP  := lm80c_core_tb
SRCS := $(shell grep -v '^+' vlog.f) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/V%: vlog.f $(SRCS)
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $* --Mdir obj_dir

# Passes only when the pass line shows up in the output
run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf obj_dir

//--- verif/lm80c_core_tb.sv
/*
 * Testbench for the LM80C glue logic core.
 * Acts as the Z80 and as the ROM download source, steps through a
 * table of bus cycles and checks the read byte, selects and strobes.
 * Clock enables and the wait and reset levels are checked around it.
 */
`timescale 1ns/10ps
`include "lm80c_settings.svh"

module lm80c_core_tb import lm80c_bus_pkg::*, lm80c_mem_pkg::*; ();

	localparam int HOLD_CYCLES = 8;  // Cycles per table step
	localparam int N_STEPS     = 22;
	localparam int WATCHDOG_CYCLES = N_STEPS * HOLD_CYCLES + 100;

	// Step kinds
	localparam logic [2:0] K_DL_WR   = 3'd0;
	localparam logic [2:0] K_MEM_WR  = 3'd1;
	localparam logic [2:0] K_MEM_RD  = 3'd2;
	localparam logic [2:0] K_IO_WR   = 3'd3;
	localparam logic [2:0] K_IO_RD   = 3'd4;
	localparam logic [2:0] K_INT_ACK = 3'd5;

	// Select patterns, order pio ctc sio vdp psg led
	localparam io_sel_t SEL_NONE = 6'b000000;
	localparam io_sel_t SEL_PIO  = 6'b100000;
	localparam io_sel_t SEL_CTC  = 6'b010000;
	localparam io_sel_t SEL_SIO  = 6'b001000;
	localparam io_sel_t SEL_VDP  = 6'b000100;
	localparam io_sel_t SEL_PSG  = 6'b000010;
	localparam io_sel_t SEL_LED  = 6'b000001;

	typedef struct packed {
		logic [2:0] kind;
		addr_t      addr;
		data_t      data;     // Write or download byte
		data_t      exp_byte; // cpu_din after the step
		io_sel_t    exp_sel;
	} step_t;

	logic         ram_clock;
	logic         RESET;
	cpu_bus_t     bus;
	periph_data_t periph;
	download_t    download;
	logic         boot_done;
	logic         reset_key;
	data_t        cpu_din;
	io_sel_t      io_sel;
	vdp_strobe_t  vdp;
	psg_ctrl_t    psg;
	logic         led;
	logic         cpu_wait;
	logic         cpu_reset;
	logic         cpu_ena;
	logic         vdp_ena;

	step_t  step_tab [0:N_STEPS-1];
	int     cpu_ena_count;
	int     vdp_ena_count;
	integer seed;
	integer rnd;
	data_t  ctc_byte;
	data_t  vdp_byte;
	data_t  psg_byte;
	data_t  led_model; // What the LED latch should hold

	lm80c_core lm80c_core_inst (
		.ram_clock   (ram_clock),
		.RESET       (RESET),
		.bus_i       (bus),
		.periph_i    (periph),
		.download_i  (download),
		.boot_done_i (boot_done),
		.reset_key_i (reset_key),
		.cpu_din_o   (cpu_din),
		.io_sel_o    (io_sel),
		.vdp_o       (vdp),
		.psg_o       (psg),
		.led_o       (led),
		.cpu_wait_o  (cpu_wait),
		.cpu_reset_o (cpu_reset),
		.cpu_ena_o   (cpu_ena),
		.vdp_ena_o   (vdp_ena)
	);

	initial begin
		ram_clock = 1'b0;
		forever #20 ram_clock = ~ram_clock; // 40 ns period
	end

	// Stops a hung run
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge ram_clock);
		$display("Timeout, the test sequence did not finish within %0d cycles",
			WATCHDOG_CYCLES);
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

	function automatic string kind_name(input logic [2:0] kind);
		case (kind)
			K_DL_WR:   return "download write";
			K_MEM_WR:  return "memory write";
			K_MEM_RD:  return "memory read";
			K_IO_WR:   return "io write";
			K_IO_RD:   return "io read";
			K_INT_ACK: return "interrupt ack";
			default:   return "unknown";
		endcase
	endfunction

	function automatic step_t make_step(input logic [2:0] kind, input addr_t addr,
		input data_t data, input data_t exp_byte, input io_sel_t exp_sel);
		step_t s;
		s.kind     = kind;
		s.addr     = addr;
		s.data     = data;
		s.exp_byte = exp_byte;
		s.exp_sel  = exp_sel;
		return s;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
			$display("sim failed");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// Expected bytes of I/O reads come from the random peripheral bytes
	task automatic load_steps();
		step_tab[0]  = make_step(K_DL_WR, 16'h0000, 8'h3E, 8'h00, SEL_NONE);
		step_tab[1]  = make_step(K_DL_WR, 16'h0001, 8'h7C, 8'h00, SEL_NONE);
		step_tab[2]  = make_step(K_DL_WR, 16'h0010, 8'hA5, 8'h00, SEL_NONE);
		step_tab[3]  = make_step(K_MEM_RD, 16'h0000, 8'h00, 8'h3E, SEL_NONE);
		step_tab[4]  = make_step(K_MEM_RD, 16'h0001, 8'h00, 8'h7C, SEL_NONE);
		step_tab[5]  = make_step(K_MEM_RD, 16'h0010, 8'h00, 8'hA5, SEL_NONE);
		step_tab[6]  = make_step(K_MEM_WR, `LM80C_RAM_LO, 8'h11, 8'hA5, SEL_NONE);
		step_tab[7]  = make_step(K_MEM_WR, `LM80C_RAM_HI - 16'h1, 8'h22, 8'hA5, SEL_NONE);
		step_tab[8]  = make_step(K_MEM_RD, `LM80C_RAM_LO, 8'h00, 8'h11, SEL_NONE);
		step_tab[9]  = make_step(K_MEM_RD, `LM80C_RAM_HI - 16'h1, 8'h00, 8'h22, SEL_NONE);
		step_tab[10] = make_step(K_MEM_WR, 16'h0010, 8'h5A, 8'h22, SEL_NONE); // ROM, ignored
		step_tab[11] = make_step(K_MEM_RD, 16'h0010, 8'h00, 8'hA5, SEL_NONE);
		step_tab[12] = make_step(K_IO_RD, {8'h00, `LM80C_CTC_NIBBLE, 4'h0}, 8'h00,
			ctc_byte, SEL_CTC);
		step_tab[13] = make_step(K_IO_RD, {8'h00, `LM80C_VDP_NIBBLE, 4'h2}, 8'h00,
			vdp_byte, SEL_VDP); // Mode bit set
		step_tab[14] = make_step(K_IO_WR, {8'h00, `LM80C_VDP_NIBBLE, 4'h0}, 8'h44,
			vdp_byte, SEL_VDP);
		step_tab[15] = make_step(K_IO_RD, {8'h00, `LM80C_PSG_NIBBLE, 4'h0}, 8'h00,
			psg_byte, SEL_PSG);
		step_tab[16] = make_step(K_IO_WR, {8'h00, `LM80C_PSG_NIBBLE, 4'h1}, 8'h66,
			psg_byte, SEL_PSG);
		step_tab[17] = make_step(K_IO_RD, {8'h00, `LM80C_PIO_NIBBLE, 4'h0}, 8'h00,
			8'h00, SEL_PIO);
		step_tab[18] = make_step(K_IO_RD, {8'h00, `LM80C_SIO_NIBBLE, 4'h0}, 8'h00,
			8'h00, SEL_SIO);
		step_tab[19] = make_step(K_IO_WR, {8'h00, `LM80C_LED_PORT}, 8'h81, 8'h00, SEL_LED);
		step_tab[20] = make_step(K_IO_RD, {8'h00, `LM80C_LED_PORT}, 8'h00, 8'h81, SEL_LED);
		step_tab[21] = make_step(K_INT_ACK, 16'h00F0, 8'h00, ctc_byte, SEL_NONE);
	endtask

	task automatic drive_step(input step_t s);
		cpu_bus_t  b;
		download_t d;
		b      = '0;
		d      = '0;
		b.addr = s.addr; // Idle address is harmless
		case (s.kind)
			K_DL_WR: begin
				d.active = 1'b1;
				d.addr   = s.addr;
				d.data   = s.data;
				d.wr     = 1'b1;
			end
			K_MEM_WR: begin
				b.mreq = 1'b1;
				b.wr   = 1'b1;
				b.dout = s.data;
			end
			K_MEM_RD: begin
				b.mreq = 1'b1;
				b.rd   = 1'b1;
			end
			K_IO_WR: begin
				b.iorq = 1'b1;
				b.wr   = 1'b1;
				b.dout = s.data;
				if (s.exp_sel.led)
					led_model = s.data;
			end
			K_IO_RD: begin
				b.iorq = 1'b1;
				b.rd   = 1'b1;
			end
			default: begin
				b.iorq = 1'b1; // Interrupt acknowledge
				b.m1   = 1'b1;
			end
		endcase
		bus      <= b;
		download <= d;
	endtask

	task automatic check_step(input int i);
		step_t       s;
		string       base;
		vdp_strobe_t exp_vdp;
		psg_ctrl_t   exp_psg;
		s    = step_tab[i];
		base = $sformatf("step %0d %s", i, kind_name(s.kind));
		exp_vdp.csr_n = ~(s.exp_sel.vdp & (s.kind == K_IO_RD));
		exp_vdp.csw_n = ~(s.exp_sel.vdp & (s.kind == K_IO_WR));
		exp_vdp.mode  = s.addr[1];
		exp_psg.bdir  = s.exp_sel.psg & (s.kind == K_IO_WR);
		exp_psg.bc    = s.exp_sel.psg & ~s.addr[0]; // Even port latches address
		check_value({base, " cpu_din"}, 32'(s.exp_byte), 32'(cpu_din));
		check_value({base, " io_sel"}, 32'(s.exp_sel), 32'(io_sel));
		check_value({base, " vdp strobes"}, 32'(exp_vdp), 32'(vdp));
		check_value({base, " psg ctrl"}, 32'(exp_psg), 32'(psg));
		check_value({base, " led"}, 32'(!led_model[0]), 32'(led));
		check_value({base, " cpu_wait"}, 32'(s.kind == K_DL_WR), 32'(cpu_wait));
		check_value({base, " cpu_reset"}, 32'd0, 32'(cpu_reset));
	endtask

	task automatic apply_step(input int i);
		@(posedge ram_clock);
		drive_step(step_tab[i]);
		@(posedge ram_clock);
		download.wr <= 1'b0; // Strobe is one cycle
		repeat (HOLD_CYCLES - 2) @(posedge ram_clock);
		@(negedge ram_clock);
		check_step(i);
	endtask

	initial begin
		cpu_ena_count = 0;
		vdp_ena_count = 0;
		seed          = 32'h2570750c;
		led_model     = '0;
		RESET     <= 1'b1;
		bus       <= '0;
		periph    <= '0;
		download  <= '0;
		boot_done <= 1'b0;
		reset_key <= 1'b0;

		repeat (10) @(posedge ram_clock);
		@(negedge ram_clock);
		// Reset state, boot not done yet
		check_value("reset io_sel", 32'(SEL_NONE), 32'(io_sel));
		check_value("reset psg ctrl", 32'd0, 32'(psg));
		check_value("reset vdp strobes", 32'b110, 32'(vdp));
		check_value("reset cpu_din", 32'd0, 32'(cpu_din));
		check_value("reset led", 32'd1, 32'(led));
		check_value("boot cpu_wait", 32'd1, 32'(cpu_wait));
		check_value("boot cpu_reset", 32'd1, 32'(cpu_reset));

		rnd      = $random(seed);
		ctc_byte = rnd[7:0];
		rnd      = $random(seed);
		vdp_byte = rnd[7:0];
		rnd      = $random(seed);
		psg_byte = rnd[7:0];

		@(posedge ram_clock);
		RESET     <= 1'b0;
		boot_done <= 1'b1;
		periph    <= '{ctc: ctc_byte, vdp: vdp_byte, psg: psg_byte};
		@(negedge ram_clock);
		check_value("first cycle cpu_ena", 32'd1, 32'(cpu_ena));
		check_value("idle cpu_wait", 32'd0, 32'(cpu_wait));
		check_value("idle cpu_reset", 32'd0, 32'(cpu_reset));

		// Ten CPU periods
		repeat (60) begin
			@(negedge ram_clock);
			if (cpu_ena)
				cpu_ena_count = cpu_ena_count + 1;
			if (vdp_ena)
				vdp_ena_count = vdp_ena_count + 1;
		end
		check_value("cpu_ena count", 32'd10, 32'(cpu_ena_count));
		check_value("vdp_ena count", 32'd30, 32'(vdp_ena_count));

		@(posedge ram_clock);
		reset_key <= 1'b1;
		@(negedge ram_clock);
		check_value("reset key pressed", 32'd1, 32'(cpu_reset));
		@(posedge ram_clock);
		reset_key <= 1'b0;
		@(negedge ram_clock);
		check_value("reset key released", 32'd0, 32'(cpu_reset));

		load_steps();
		for (int i = 0; i < N_STEPS; i++)
			apply_step(i);

		$display("sim passed");
		$finish;
	end

endmodule

//--- verilog/lm80c_core.sv
/*
 * Top level of the LM80C glue logic.
 * Connects the clock enables with the decode, execute and result
 * stages. The video, sound and timer chips sit outside.
 */
`timescale 1ns/10ps

module lm80c_core import lm80c_bus_pkg::*, lm80c_mem_pkg::*; (
	input  logic         ram_clock,
	input  logic         RESET,
	input  cpu_bus_t     bus_i,
	input  periph_data_t periph_i,
	input  download_t    download_i,
	input  logic         boot_done_i,
	input  logic         reset_key_i,
	output data_t        cpu_din_o,
	output io_sel_t      io_sel_o,
	output vdp_strobe_t  vdp_o,
	output psg_ctrl_t    psg_o,
	output logic         led_o,
	output logic         cpu_wait_o,
	output logic         cpu_reset_o,
	output logic         cpu_ena_o,
	output logic         vdp_ena_o
);

	logic  ram_sel;
	data_t ram_q;   // RAM byte into the read mux

	lm80c_clock_enables lm80c_clock_enables_inst (
		.ram_clock (ram_clock),
		.RESET     (RESET),
		.cpu_ena_o (cpu_ena_o),
		.vdp_ena_o (vdp_ena_o)
	);

	lm80c_bus_decoder lm80c_bus_decoder_inst (
		.ram_clock (ram_clock),
		.RESET     (RESET),
		.bus_i     (bus_i),
		.io_sel_o  (io_sel_o),
		.ram_sel_o (ram_sel),
		.rom_sel_o (),
		.vdp_o     (vdp_o),
		.psg_o     (psg_o)
	);

	lm80c_memory_port lm80c_memory_port_inst (
		.ram_clock   (ram_clock),
		.RESET       (RESET),
		.bus_i       (bus_i),
		.ram_sel_i   (ram_sel),
		.download_i  (download_i),
		.boot_done_i (boot_done_i),
		.reset_key_i (reset_key_i),
		.ram_q_o     (ram_q),
		.cpu_wait_o  (cpu_wait_o),
		.cpu_reset_o (cpu_reset_o)
	);

	lm80c_read_mux lm80c_read_mux_inst (
		.ram_clock (ram_clock),
		.RESET     (RESET),
		.bus_i     (bus_i),
		.io_sel_i  (io_sel_o),
		.periph_i  (periph_i),
		.ram_q_i   (ram_q),
		.cpu_din_o (cpu_din_o),
		.led_o     (led_o)
	);

endmodule

//--- verilog/lm80c_read_mux.sv
/*
 * Result stage of the glue logic.
 * Registers the byte that the CPU reads and holds the LED port latch.
 * On an interrupt acknowledge the CTC byte is the vector.
 */
`timescale 1ns/10ps

module lm80c_read_mux import lm80c_bus_pkg::*; (
	input  logic         ram_clock,
	input  logic         RESET,
	input  cpu_bus_t     bus_i,
	input  io_sel_t      io_sel_i,
	input  periph_data_t periph_i,
	input  data_t        ram_q_i,
	output data_t        cpu_din_o,
	output logic         led_o
);

	data_t led_latch;
	data_t rd_byte;   // Read source by priority

	always_comb begin
		if (io_sel_i.pio)
			rd_byte = '0; // No PIO model
		else if (io_sel_i.ctc)
			rd_byte = periph_i.ctc;
		else if (io_sel_i.sio)
			rd_byte = '0; // No SIO model
		else if (io_sel_i.vdp)
			rd_byte = periph_i.vdp;
		else if (io_sel_i.psg)
			rd_byte = periph_i.psg;
		else if (io_sel_i.led)
			rd_byte = led_latch;
		else
			rd_byte = ram_q_i; // Memory read
	end

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			cpu_din_o <= '0;
			led_latch <= '0;
		end else begin
			if (bus_i.rd)
				cpu_din_o <= rd_byte;
			else if (bus_i.iorq && bus_i.m1)
				cpu_din_o <= periph_i.ctc; // Interrupt vector
			// Otherwise the last byte stays

			if (io_sel_i.led && bus_i.wr)
				led_latch <= bus_i.dout;
		end
	end

	assign led_o = ~led_latch[0]; // LED lights on a low pin

endmodule

//--- verilog/lm80c_memory_port.sv
/*
 * Execute stage of the glue logic.
 * Arbitrates the ROM download against the CPU, holds the 64 KB
 * system RAM and drives the CPU wait and reset levels.
 * The download owns the RAM whenever it is active.
 */
`timescale 1ns/10ps
`include "lm80c_settings.svh"

module lm80c_memory_port import lm80c_bus_pkg::*, lm80c_mem_pkg::*; (
	input  logic      ram_clock,
	input  logic      RESET,
	input  cpu_bus_t  bus_i,
	input  logic      ram_sel_i,   // From the decoder, one cycle behind the bus
	input  download_t download_i,
	input  logic      boot_done_i,
	input  logic      reset_key_i,
	output data_t     ram_q_o,
	output logic      cpu_wait_o,
	output logic      cpu_reset_o
);

	cpu_bus_t bus_q;  // Bus aligned with ram_sel_i
	mem_req_t req;
	logic     req_dl; // Request came from the download
	data_t    mem [0:`LM80C_RAM_DEPTH-1];

	// Delay the bus so that the RAM select matches its address
	always_ff @(posedge ram_clock) begin
		if (RESET)
			bus_q <= '0;
		else
			bus_q <= bus_i;
	end

	// Request register, download first
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			req.wr <= 1'b0;
			req_dl <= 1'b0;
		end else if (download_i.active) begin
			req.wr <= download_i.wr; // Single-cycle strobe
			req_dl <= 1'b1;
		end else begin
			req.wr <= bus_q.wr & bus_q.mreq & ram_sel_i; // RAM window only
			req_dl <= 1'b0;
		end
	end

	always_ff @(posedge ram_clock) begin
		if (download_i.active) begin
			req.addr <= download_i.addr;
			req.data <= download_i.data;
		end else begin
			req.addr <= bus_q.addr;
			req.data <= bus_q.dout;
		end
	end

	// System RAM with registered read
	always_ff @(posedge ram_clock) begin
		if (req.wr)
			mem[req.addr] <= req.data;
		ram_q_o <= mem[req.addr];
	end

	// CPU stalls during boot and download
	assign cpu_wait_o  = ~boot_done_i | download_i.active;
	assign cpu_reset_o = ~boot_done_i | reset_key_i; // Reset key or boot

	// ROM is only written by the download
	a_no_cpu_rom_write: assert property (@(posedge ram_clock) disable iff (RESET)
		(req.wr && !req_dl) |-> (req.addr >= `LM80C_ROM_TOP));

endmodule

//--- verilog/lm80c_bus_decoder.sv
/*
 * Decode stage of the glue logic.
 * Turns the CPU bus into registered chip selects, RAM and ROM
 * selects, the video chip strobes and the sound chip bus controls.
 * Every output follows the bus by one ram_clock cycle.
 */
`timescale 1ns/10ps
`include "lm80c_settings.svh"

module lm80c_bus_decoder import lm80c_bus_pkg::*; (
	input  logic        ram_clock,
	input  logic        RESET,
	input  cpu_bus_t    bus_i,
	output io_sel_t     io_sel_o,
	output logic        ram_sel_o,
	output logic        rom_sel_o,
	output vdp_strobe_t vdp_o,
	output psg_ctrl_t   psg_o
);

	logic        io_cyc;  // I/O cycle, not a memory cycle
	logic [3:0]  port_hi; // Chip nibble of the port
	io_sel_t     sel_d;
	vdp_strobe_t vdp_d;
	psg_ctrl_t   psg_d;
	logic        ram_d;
	logic        rom_d;

	assign io_cyc  = bus_i.iorq & ~bus_i.mreq;
	assign port_hi = bus_i.addr[7:4];

	always_comb begin
		sel_d.pio = io_cyc & (port_hi == `LM80C_PIO_NIBBLE);
		sel_d.ctc = io_cyc & (port_hi == `LM80C_CTC_NIBBLE);
		sel_d.sio = io_cyc & (port_hi == `LM80C_SIO_NIBBLE);
		sel_d.vdp = io_cyc & (port_hi == `LM80C_VDP_NIBBLE);
		sel_d.psg = io_cyc & (port_hi == `LM80C_PSG_NIBBLE);
		sel_d.led = io_cyc & (bus_i.addr[7:0] == `LM80C_LED_PORT); // Full byte

		// VDP strobes drop while selected
		vdp_d.csr_n = ~(sel_d.vdp & bus_i.rd);
		vdp_d.csw_n = ~(sel_d.vdp & bus_i.wr);
		vdp_d.mode  = bus_i.addr[1];

		// PSG latch address on even port, write data on odd
		psg_d.bdir = sel_d.psg & bus_i.wr;
		psg_d.bc   = sel_d.psg & ~bus_i.addr[0];

		ram_d = bus_i.mreq & (bus_i.addr >= `LM80C_RAM_LO) &
			(bus_i.addr < `LM80C_RAM_HI);
		rom_d = bus_i.mreq & (bus_i.addr < `LM80C_ROM_TOP);
	end

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			io_sel_o  <= '0;
			ram_sel_o <= 1'b0;
			rom_sel_o <= 1'b0;
			vdp_o     <= '{csr_n: 1'b1, csw_n: 1'b1, mode: 1'b0}; // Strobes idle high
			psg_o     <= '0; // PSG inactive
		end else begin
			io_sel_o  <= sel_d;
			ram_sel_o <= ram_d;
			rom_sel_o <= rom_d;
			vdp_o     <= vdp_d;
			psg_o     <= psg_d;
		end
	end

	// Chip nibbles never overlap
	a_chip_sel_onehot: assert property (@(posedge ram_clock) disable iff (RESET)
		$onehot0({io_sel_o.pio, io_sel_o.ctc, io_sel_o.sio, io_sel_o.vdp, io_sel_o.psg}));

endmodule

//--- verilog/lm80c_clock_enables.sv
/*
 * Clock enables for the CPU and the video chip.
 * Both counters restart on RESET, so each enable is high in the
 * first cycle after RESET falls.
 */
`timescale 1ns/10ps
`include "lm80c_settings.svh"

module lm80c_clock_enables (
	input  logic ram_clock,
	input  logic RESET,
	output logic cpu_ena_o, // One cycle in six
	output logic vdp_ena_o  // Every other cycle
);

	localparam int CPU_W = $clog2(`LM80C_CPU_DIV);
	localparam int VDP_W = $clog2(`LM80C_VDP_DIV);

	logic [CPU_W-1:0] cpu_cnt;
	logic [VDP_W-1:0] vdp_cnt; // Plain toggle at period 2

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			cpu_cnt <= '0;
			vdp_cnt <= '0;
		end else begin
			if (cpu_cnt == CPU_W'(`LM80C_CPU_DIV - 1))
				cpu_cnt <= '0; // Wrap
			else
				cpu_cnt <= cpu_cnt + 1'b1;
			if (vdp_cnt == VDP_W'(`LM80C_VDP_DIV - 1))
				vdp_cnt <= '0;
			else
				vdp_cnt <= vdp_cnt + 1'b1;
		end
	end

	assign cpu_ena_o = (cpu_cnt == '0);
	assign vdp_ena_o = (vdp_cnt == '0);

	// CPU enable is a single-cycle pulse
	a_cpu_ena_pulse: assert property (@(posedge ram_clock) disable iff (RESET)
		cpu_ena_o |=> !cpu_ena_o);

endmodule

//--- verilog/lm80c_mem_pkg.sv
/*
 * Memory-side types.
 * The system RAM address, the request that the memory port
 * registers each cycle and the ROM download write.
 */
package lm80c_mem_pkg;

	import lm80c_bus_pkg::*;

	typedef logic [15:0] mem_addr_t; // System RAM address

	// One RAM access, read always, write on wr
	typedef struct packed {
		mem_addr_t addr;
		data_t     data;
		logic      wr;
	} mem_req_t;

	// Download source; wr pulses for one cycle per byte
	typedef struct packed {
		logic      active; // Held high for the whole download
		mem_addr_t addr;
		data_t     data;
		logic      wr;
	} download_t;

endpackage

//--- verilog/lm80c_bus_pkg.sv
/*
 * CPU-side bus types.
 * The Z80 bus with its control lines already active high, the
 * registered peripheral selects, the peripheral read bytes and the
 * strobes that go out to the video and sound chips.
 */
package lm80c_bus_pkg;

	typedef logic [15:0] addr_t; // CPU address
	typedef logic [7:0]  data_t; // One byte

	// Z80 bus as seen by the glue logic
	typedef struct packed {
		addr_t addr;
		data_t dout; // CPU write data
		logic  rd;
		logic  wr;
		logic  iorq;
		logic  mreq;
		logic  m1;
	} cpu_bus_t;

	// Registered chip selects
	typedef struct packed {
		logic pio;
		logic ctc;
		logic sio;
		logic vdp;
		logic psg;
		logic led; // Port 255 only
	} io_sel_t;

	// Read bytes of the external chips
	typedef struct packed {
		data_t ctc; // Also the interrupt vector
		data_t vdp;
		data_t psg;
	} periph_data_t;

	typedef struct packed {
		logic csr_n; // Read strobe, low active
		logic csw_n; // Write strobe, low active
		logic mode;  // Register or VRAM access
	} vdp_strobe_t;

	typedef struct packed {
		logic bdir;
		logic bc;
	} psg_ctrl_t;

endpackage

//--- verilog/lm80c_settings.svh
/*
 * Fixed numbers of the LM80C glue logic.
 * I/O port nibbles, the memory map and the clock-enable ratios.
 * Include in any file that decodes addresses or paces the chips.
 */
`ifndef LM80C_SETTINGS_SVH
`define LM80C_SETTINGS_SVH

// High nibble of the I/O port for each chip
`define LM80C_PIO_NIBBLE 4'd0
`define LM80C_CTC_NIBBLE 4'd1
`define LM80C_SIO_NIBBLE 4'd2
`define LM80C_VDP_NIBBLE 4'd3
`define LM80C_PSG_NIBBLE 4'd4

// Debug LED decodes the whole low byte
`define LM80C_LED_PORT 8'd255

// Writable RAM window, upper bound excluded
`define LM80C_RAM_LO 16'h8000
`define LM80C_RAM_HI 16'hC000

// Everything below this is ROM
`define LM80C_ROM_TOP 16'h8000

// System RAM size in bytes
`define LM80C_RAM_DEPTH 65536

// Clock-enable periods in ram_clock cycles
`define LM80C_CPU_DIV 6
`define LM80C_VDP_DIV 2

`endif
